// File: source/cache_pkg.sv
package cache_pkg;

	// words per cache line, fixes the line type width
	localparam int LINE_WORDS = 4;

	// one full cache line, word 0 in the low bits
	typedef logic [LINE_WORDS-1:0][31:0] line_data_t;

	// request from the pipeline to one memory part
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		// 1 for a store
		logic        rw;
		logic        valid;
	} cpu_req_t;

	// answer back to the pipeline
	typedef struct packed {
		logic [31:0] data;
		// load data valid or store done this cycle
		logic        ready;
	} cpu_result_t;

	// miss handling states of the data cache
	typedef enum logic [1:0] {
		ST_COMPARE,
		ST_WRITE_BACK,
		ST_ALLOCATE
	} cache_state_e;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

	// memory operation of the instruction in MEM
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	// source of the register writeback value
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	// addr[31:28] of the uncached register block
	localparam logic [3:0] IO_REGION = 4'hF;

endpackage

// File: source/mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if;

	// request side, held stable until ready
	logic                    valid;
	logic                    we;
	logic [31:0]             line_addr;
	cache_pkg::line_data_t   wdata;
	// answer side, ready is a one-cycle pulse
	logic                    ready;
	cache_pkg::line_data_t   rdata;

	modport master (
		output valid, we, line_addr, wdata,
		input  ready, rdata
	);

	modport slave (
		input  valid, we, line_addr, wdata,
		output ready, rdata
	);

endinterface

// File: source/d_cache.sv
`timescale 1ns/100ps

module d_cache #(
	parameter int NUM_LINES = 16
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  cache_pkg::cpu_req_t    cpu_req_i,
	output cache_pkg::cpu_result_t cpu_res_o,
	mem_bus_if.master              mem,
	output logic [31:0]            acc_cnt_o,
	output logic [31:0]            hit_cnt_o,
	output logic [31:0]            miss_cnt_o
);

	// address split: tag | index | word | byte
	localparam int WORD_W   = $clog2(cache_pkg::LINE_WORDS);
	localparam int OFFSET_W = WORD_W + 2;
	localparam int INDEX_W  = $clog2(NUM_LINES);
	localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

	cache_pkg::cache_state_e state_q, state_d;

	// per-line status, cleared by reset
	logic [NUM_LINES-1:0] valid_q;
	logic [NUM_LINES-1:0] dirty_q;
	// tag and data storage
	logic [TAG_W-1:0]          tag_arr  [NUM_LINES];
	cache_pkg::line_data_t     data_arr [NUM_LINES];

	// set once the line was refilled for this access
	logic miss_q;

	logic [31:0] acc_q, hit_q, miss_cnt_q;

	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0]   req_tag;
	logic [WORD_W-1:0]  word;
	logic               hit;
	logic               alloc_done;

	assign idx     = cpu_req_i.addr[OFFSET_W +: INDEX_W];
	assign req_tag = cpu_req_i.addr[31 -: TAG_W];
	assign word    = cpu_req_i.addr[2 +: WORD_W];

	// tag compare and next state
	always_comb begin
		state_d = state_q;
		hit     = 1'b0;
		case (state_q)
			cache_pkg::ST_COMPARE: begin
				if (cpu_req_i.valid) begin
					if (valid_q[idx] && (tag_arr[idx] == req_tag)) begin
						hit = 1'b1;
					end else if (valid_q[idx] && dirty_q[idx]) begin
						// old line must go out first
						state_d = cache_pkg::ST_WRITE_BACK;
					end else begin
						state_d = cache_pkg::ST_ALLOCATE;
					end
				end
			end
			cache_pkg::ST_WRITE_BACK: begin
				if (mem.ready) begin
					state_d = cache_pkg::ST_ALLOCATE;
				end
			end
			cache_pkg::ST_ALLOCATE: begin
				// retry the compare, which hits now
				if (mem.ready) begin
					state_d = cache_pkg::ST_COMPARE;
				end
			end
			default: state_d = cache_pkg::ST_COMPARE;
		endcase
	end

	assign alloc_done = (state_q == cache_pkg::ST_ALLOCATE) && mem.ready;

	// bus request stays up for the whole miss state
	assign mem.valid = (state_q != cache_pkg::ST_COMPARE);
	assign mem.we    = (state_q == cache_pkg::ST_WRITE_BACK);
	assign mem.wdata = data_arr[idx];
	// victim address rebuilt from the stored tag
	assign mem.line_addr = (state_q == cache_pkg::ST_WRITE_BACK) ?
		{tag_arr[idx], idx, {OFFSET_W{1'b0}}} :
		{cpu_req_i.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

	assign cpu_res_o.ready = hit;
	assign cpu_res_o.data  = data_arr[idx][word];

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			state_q    <= cache_pkg::ST_COMPARE;
			valid_q    <= '0;
			dirty_q    <= '0;
			miss_q     <= 1'b0;
			acc_q      <= '0;
			hit_q      <= '0;
			miss_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// refilled line is clean
			if (alloc_done) begin
				valid_q[idx] <= 1'b1;
				dirty_q[idx] <= 1'b0;
				miss_q       <= 1'b1;
			end
			if (hit && cpu_req_i.rw) begin
				dirty_q[idx] <= 1'b1;
			end
			// classify the access when it completes
			if (hit) begin
				acc_q  <= acc_q + 32'd1;
				miss_q <= 1'b0;
				if (miss_q) begin
					miss_cnt_q <= miss_cnt_q + 32'd1;
				end else begin
					hit_q <= hit_q + 32'd1;
				end
			end
		end
	end

	// line storage
	always_ff @(posedge clk_i) begin
		if (alloc_done) begin
			data_arr[idx] <= mem.rdata;
			tag_arr[idx]  <= req_tag;
		end else if (hit && cpu_req_i.rw) begin
			data_arr[idx][word] <= cpu_req_i.data;
		end
	end

	assign acc_cnt_o  = acc_q;
	assign hit_cnt_o  = hit_q;
	assign miss_cnt_o = miss_cnt_q;

endmodule

// File: source/io_regs.sv
`timescale 1ns/100ps

module io_regs (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  cache_pkg::cpu_req_t    req_i,
	output cache_pkg::cpu_result_t res_o,
	output logic [31:0]            led_o
);

	logic [31:0] regs_q [4];
	logic [1:0]  sel;

	// word select within the block
	assign sel = req_i.addr[3:2];

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < 4; i++) begin
				regs_q[i] <= '0;
			end
		end else if (req_i.valid && req_i.rw) begin
			regs_q[sel] <= req_i.data;
		end
	end

	// no wait states
	assign res_o.ready = req_i.valid;
	assign res_o.data  = regs_q[sel];

	// register 0 is the led port
	assign led_o = regs_q[0];

endmodule

// File: source/main_memory.sv
`timescale 1ns/100ps

module main_memory #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3
) (
	input  logic      clk_i,
	input  logic      rst_ni,
	mem_bus_if.slave  bus
);

	localparam int ADDR_W = $clog2(MEM_WORDS);
	localparam int CNT_W  = $clog2(MEM_LATENCY + 1) + 1;

	logic [31:0]       mem_arr [MEM_WORDS];
	logic [CNT_W-1:0]  cnt_q;
	logic              ready_q;
	logic [ADDR_W-1:0] base;

	// first word of the line
	assign base = bus.line_addr[ADDR_W+1:2];

	// known fill pattern
	initial begin
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem_arr[w] = w ^ 32'hA5A5_0000;
		end
	end

	// latency count and one-cycle ready
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q   <= '0;
			ready_q <= 1'b0;
		end else if (ready_q) begin
			// transfer completes on this edge
			ready_q <= 1'b0;
		end else if (bus.valid) begin
			if (cnt_q == CNT_W'(MEM_LATENCY - 1)) begin
				cnt_q   <= '0;
				ready_q <= 1'b1;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// line access when the count expires
	always_ff @(posedge clk_i) begin
		if (!ready_q && bus.valid && (cnt_q == CNT_W'(MEM_LATENCY - 1))) begin
			for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
				if (bus.we) begin
					mem_arr[base + ADDR_W'(w)] <= bus.wdata[w];
				end else begin
					bus.rdata[w] <= mem_arr[base + ADDR_W'(w)];
				end
			end
		end
	end

	assign bus.ready = ready_q;

endmodule

// File: source/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic [31:0]            alu_i,
	input  logic [31:0]            rs2_i,
	input  logic [31:0]            pc4_i,
	input  logic [31:0]            inst_i,
	input  pipe_pkg::mem_op_e      mem_op_i,
	input  pipe_pkg::wb_sel_e      wb_sel_i,
	input  logic                   reg_wen_i,
	input  logic [4:0]             rd_i,
	input  logic                   enable_i,
	input  logic                   flush_i,
	input  logic                   stall_by_icache_i,
	output logic [31:0]            alu_wb_o,
	output logic [31:0]            pc4_wb_o,
	output logic [31:0]            mem_wb_o,
	output logic [31:0]            inst_wb_o,
	output pipe_pkg::wb_sel_e      wb_sel_wb_o,
	output logic                   reg_wen_wb_o,
	output logic [4:0]             rd_wb_o,
	output logic                   stall_o,
	output cache_pkg::cpu_req_t    dc_req_o,
	input  cache_pkg::cpu_result_t dc_res_i,
	output cache_pkg::cpu_req_t    io_req_o,
	input  cache_pkg::cpu_result_t io_res_i
);

	logic        is_io;
	logic        mem_act;
	logic [31:0] load_data;

	// address decode
	assign is_io   = (alu_i[31:28] == pipe_pkg::IO_REGION);
	// no request while fetch is stalled
	assign mem_act = (mem_op_i != pipe_pkg::MEM_NONE) && !stall_by_icache_i;

	assign dc_req_o.addr  = alu_i;
	assign dc_req_o.data  = rs2_i;
	assign dc_req_o.rw    = (mem_op_i == pipe_pkg::MEM_STORE);
	assign dc_req_o.valid = mem_act && !is_io;

	assign io_req_o.addr  = alu_i;
	assign io_req_o.data  = rs2_i;
	assign io_req_o.rw    = (mem_op_i == pipe_pkg::MEM_STORE);
	assign io_req_o.valid = mem_act && is_io;

	// result merge, zero unless a load
	assign load_data = (mem_op_i != pipe_pkg::MEM_LOAD) ? 32'd0 :
		is_io ? io_res_i.data : dc_res_i.data;

	// hold upstream until the selected part answers
	assign stall_o = (dc_req_o.valid && !dc_res_i.ready) ||
		(io_req_o.valid && !io_res_i.ready);

	// MEM/WB register
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			alu_wb_o     <= '0;
			pc4_wb_o     <= '0;
			mem_wb_o     <= '0;
			inst_wb_o    <= '0;
			wb_sel_wb_o  <= pipe_pkg::WB_ALU;
			reg_wen_wb_o <= 1'b0;
			rd_wb_o      <= '0;
		end else if (enable_i && !stall_o) begin
			if (flush_i) begin
				// bubble
				alu_wb_o     <= '0;
				pc4_wb_o     <= '0;
				mem_wb_o     <= '0;
				inst_wb_o    <= '0;
				wb_sel_wb_o  <= pipe_pkg::WB_ALU;
				reg_wen_wb_o <= 1'b0;
				rd_wb_o      <= '0;
			end else begin
				alu_wb_o     <= alu_i;
				pc4_wb_o     <= pc4_i;
				mem_wb_o     <= load_data;
				inst_wb_o    <= inst_i;
				wb_sel_wb_o  <= wb_sel_i;
				reg_wen_wb_o <= reg_wen_i;
				rd_wb_o      <= rd_i;
			end
		end
	end

endmodule

// File: source/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top #(
	parameter int NUM_LINES   = 16,
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 3
) (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic [31:0]       alu_i,
	input  logic [31:0]       rs2_i,
	input  logic [31:0]       pc4_i,
	input  logic [31:0]       inst_i,
	input  pipe_pkg::mem_op_e mem_op_i,
	input  pipe_pkg::wb_sel_e wb_sel_i,
	input  logic              reg_wen_i,
	input  logic [4:0]        rd_i,
	input  logic              enable_i,
	input  logic              flush_i,
	input  logic              stall_by_icache_i,
	output logic [31:0]       alu_wb_o,
	output logic [31:0]       pc4_wb_o,
	output logic [31:0]       mem_wb_o,
	output logic [31:0]       inst_wb_o,
	output pipe_pkg::wb_sel_e wb_sel_wb_o,
	output logic              reg_wen_wb_o,
	output logic [4:0]        rd_wb_o,
	output logic              stall_o,
	output logic [31:0]       acc_cnt_o,
	output logic [31:0]       hit_cnt_o,
	output logic [31:0]       miss_cnt_o,
	output logic [31:0]       led_o
);

	// requests and answers of both parts
	cache_pkg::cpu_req_t    dc_req, io_req;
	cache_pkg::cpu_result_t dc_res, io_res;

	// cache refill bus
	mem_bus_if bus_if ();

	mem_stage u_mem_stage (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.alu_i             (alu_i),
		.rs2_i             (rs2_i),
		.pc4_i             (pc4_i),
		.inst_i            (inst_i),
		.mem_op_i          (mem_op_i),
		.wb_sel_i          (wb_sel_i),
		.reg_wen_i         (reg_wen_i),
		.rd_i              (rd_i),
		.enable_i          (enable_i),
		.flush_i           (flush_i),
		.stall_by_icache_i (stall_by_icache_i),
		.alu_wb_o          (alu_wb_o),
		.pc4_wb_o          (pc4_wb_o),
		.mem_wb_o          (mem_wb_o),
		.inst_wb_o         (inst_wb_o),
		.wb_sel_wb_o       (wb_sel_wb_o),
		.reg_wen_wb_o      (reg_wen_wb_o),
		.rd_wb_o           (rd_wb_o),
		.stall_o           (stall_o),
		.dc_req_o          (dc_req),
		.dc_res_i          (dc_res),
		.io_req_o          (io_req),
		.io_res_i          (io_res)
	);

	d_cache #(
		.NUM_LINES (NUM_LINES)
	) u_d_cache (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.cpu_req_i  (dc_req),
		.cpu_res_o  (dc_res),
		.mem        (bus_if.master),
		.acc_cnt_o  (acc_cnt_o),
		.hit_cnt_o  (hit_cnt_o),
		.miss_cnt_o (miss_cnt_o)
	);

	io_regs u_io_regs (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.req_i  (io_req),
		.res_o  (io_res),
		.led_o  (led_o)
	);

	main_memory #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_main_memory (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.bus    (bus_if.slave)
	);

endmodule

// File: bench/mem_subsys_properties.sv
`timescale 1ns/100ps

module mem_subsys_properties (
	input logic                clk_i,
	input logic                rst_ni,
	input logic                stall_i,
	input logic                flush_i,
	input logic                enable_i,
	input logic                reg_wen_wb_i,
	input cache_pkg::cpu_req_t dc_req_i,
	input cache_pkg::cpu_req_t io_req_i
);

	// failed assertions, read by the testbench at the end
	int fail_count = 0;

	// upstream holds the request until the part answers
	req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		stall_i |=> ($stable(dc_req_i) && $stable(io_req_i)))
	else begin
		fail_count++;
		$error("request changed while the stage was stalled");
	end

	// a taken flush leaves a bubble
	flush_bubble_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(flush_i && enable_i && !stall_i) |=> !reg_wen_wb_i)
	else begin
		fail_count++;
		$error("register write enable set after a flush");
	end

endmodule

bind mem_stage mem_subsys_properties u_props (
	.clk_i        (clk_i),
	.rst_ni       (rst_ni),
	.stall_i      (stall_o),
	.flush_i      (flush_i),
	.enable_i     (enable_i),
	.reg_wen_wb_i (reg_wen_wb_o),
	.dc_req_i     (dc_req_o),
	.io_req_i     (io_req_o)
);

// File: bench/tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys;

	localparam int NUM_LINES    = 16;
	localparam int MEM_WORDS    = 1024;
	localparam int MEM_LATENCY  = 3;
	// upper bound on memory accesses over all tests
	localparam int NUM_ACCESSES = 80;
	localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 2 * (MEM_LATENCY + 1) + 50;

	logic              clk_i, rst_ni;
	logic [31:0]       alu_i, rs2_i, pc4_i, inst_i;
	pipe_pkg::mem_op_e mem_op_i;
	pipe_pkg::wb_sel_e wb_sel_i;
	logic              reg_wen_i;
	logic [4:0]        rd_i;
	logic              enable_i, flush_i, stall_by_icache_i;
	logic [31:0]       alu_wb_o, pc4_wb_o, mem_wb_o, inst_wb_o;
	pipe_pkg::wb_sel_e wb_sel_wb_o;
	logic              reg_wen_wb_o;
	logic [4:0]        rd_wb_o;
	logic              stall_o;
	logic [31:0]       acc_cnt_o, hit_cnt_o, miss_cnt_o, led_o;

	// reference model: flat memory view, tag copy, io registers
	logic [31:0]          model_mem [MEM_WORDS];
	logic [23:0]          model_tag [NUM_LINES];
	logic [NUM_LINES-1:0] model_valid;
	logic [31:0]          model_io [4];
	logic [31:0]          exp_acc, exp_hit, exp_miss;

	logic [31:0] lcg_state;
	int          errors, tests_run, tests_failed, test_start_errors, total_errors;

	mem_subsys_top #(
		.NUM_LINES   (NUM_LINES),
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) DUT (
		.clk_i (clk_i), .rst_ni (rst_ni), .alu_i (alu_i), .rs2_i (rs2_i),
		.pc4_i (pc4_i), .inst_i (inst_i), .mem_op_i (mem_op_i), .wb_sel_i (wb_sel_i),
		.reg_wen_i (reg_wen_i), .rd_i (rd_i), .enable_i (enable_i), .flush_i (flush_i),
		.stall_by_icache_i (stall_by_icache_i), .alu_wb_o (alu_wb_o), .pc4_wb_o (pc4_wb_o),
		.mem_wb_o (mem_wb_o), .inst_wb_o (inst_wb_o), .wb_sel_wb_o (wb_sel_wb_o),
		.reg_wen_wb_o (reg_wen_wb_o), .rd_wb_o (rd_wb_o), .stall_o (stall_o),
		.acc_cnt_o (acc_cnt_o), .hit_cnt_o (hit_cnt_o), .miss_cnt_o (miss_cnt_o),
		.led_o (led_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// hard stop if an access never completes
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_sel(input string name, input pipe_pkg::wb_sel_e got,
		input pipe_pkg::wb_sel_e exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_counters();
		check_count("acc_cnt_o", acc_cnt_o, exp_acc);
		check_count("hit_cnt_o", hit_cnt_o, exp_hit);
		check_count("miss_cnt_o", miss_cnt_o, exp_miss);
	endtask

	// hit if the line holds this tag, else a refill
	task automatic model_cached(input logic [31:0] addr);
		logic [3:0] idx;
		idx = addr[7:4];
		exp_acc = exp_acc + 32'd1;
		if (model_valid[idx] && (model_tag[idx] == addr[31:8])) begin
			exp_hit = exp_hit + 32'd1;
		end else begin
			exp_miss = exp_miss + 32'd1;
			model_valid[idx] = 1'b1;
			model_tag[idx] = addr[31:8];
		end
	endtask

	// one load or store, started and ended on a falling edge
	task automatic do_access(input pipe_pkg::mem_op_e op, input logic [31:0] addr,
		input logic [31:0] wdata, output logic saw_stall);
		logic        is_io;
		logic        is_load;
		logic [31:0] exp_data;
		int          waited;
		is_io = (addr[31:28] == pipe_pkg::IO_REGION);
		is_load = (op == pipe_pkg::MEM_LOAD);
		exp_data = 32'd0;
		if (is_load) begin
			exp_data = is_io ? model_io[addr[3:2]] : model_mem[addr[11:2]];
		end
		alu_i = addr;
		rs2_i = wdata;
		mem_op_i = op;
		wb_sel_i = is_load ? pipe_pkg::WB_MEM : pipe_pkg::WB_ALU;
		reg_wen_i = is_load;
		rd_i = addr[6:2];
		saw_stall = 1'b0;
		waited = 0;
		// sample stall inside the low phase
		#10;
		while (stall_o && (waited < 4 * (MEM_LATENCY + 1) + 4)) begin
			saw_stall = 1'b1;
			waited++;
			@(negedge clk_i);
			#10;
		end
		if (stall_o) begin
			$display("access to %h still stalled after %0d cycles", addr, waited);
			errors++;
		end
		@(posedge clk_i);
		@(negedge clk_i);
		if (!is_io) begin
			model_cached(addr);
		end
		if (!is_load && is_io) begin
			model_io[addr[3:2]] = wdata;
		end else if (!is_load) begin
			model_mem[addr[11:2]] = wdata;
		end
		check_word("mem_wb_o", mem_wb_o, exp_data);
		check_word("alu_wb_o", alu_wb_o, addr);
		check_sel("wb_sel_wb_o", wb_sel_wb_o, wb_sel_i);
		check_word("reg_wen_wb_o", 32'(reg_wen_wb_o), 32'(is_load));
		mem_op_i = pipe_pkg::MEM_NONE;
		reg_wen_i = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	task automatic test_reset();
		#10;
		check_word("alu_wb_o", alu_wb_o, 32'd0);
		check_word("pc4_wb_o", pc4_wb_o, 32'd0);
		check_word("mem_wb_o", mem_wb_o, 32'd0);
		check_word("inst_wb_o", inst_wb_o, 32'd0);
		check_sel("wb_sel_wb_o", wb_sel_wb_o, pipe_pkg::WB_ALU);
		check_word("reg_wen_wb_o", 32'(reg_wen_wb_o), 32'd0);
		check_word("rd_wb_o", 32'(rd_wb_o), 32'd0);
		check_word("stall_o", 32'(stall_o), 32'd0);
		check_word("led_o", led_o, 32'd0);
		check_counters();
		@(negedge clk_i);
		end_test("reset");
	endtask

	task automatic test_cached_loads();
		logic stalled;
		// untouched line misses
		do_access(pipe_pkg::MEM_LOAD, 32'h0000_0100, 32'd0, stalled);
		if (!stalled) begin
			$display("no stall seen during the refill of line 0x100");
			errors++;
		end
		check_counters();
		// same line now hits
		do_access(pipe_pkg::MEM_LOAD, 32'h0000_0104, 32'd0, stalled);
		check_counters();
		end_test("cached_loads");
	endtask

	task automatic test_eviction();
		logic        stalled;
		logic [31:0] data;
		data = next_random();
		do_access(pipe_pkg::MEM_STORE, 32'h0000_0230, data, stalled);
		// same index, other tag, dirty victim goes out
		do_access(pipe_pkg::MEM_LOAD, 32'h0000_0330, 32'd0, stalled);
		do_access(pipe_pkg::MEM_LOAD, 32'h0000_0230, 32'd0, stalled);
		check_word("mem_wb_o", mem_wb_o, data);
		check_counters();
		end_test("eviction");
	endtask

	task automatic test_io();
		logic        stalled;
		logic [31:0] data;
		data = next_random();
		do_access(pipe_pkg::MEM_STORE, 32'hF000_0000, data, stalled);
		check_word("led_o", led_o, data);
		do_access(pipe_pkg::MEM_LOAD, 32'hF000_0000, 32'd0, stalled);
		check_word("mem_wb_o", mem_wb_o, data);
		// uncached, counters untouched
		check_counters();
		end_test("io_region");
	endtask

	task automatic test_pipeline();
		logic [31:0] alu_v, pc4_v, inst_v;
		alu_v = next_random();
		pc4_v = next_random();
		inst_v = next_random();
		alu_i = alu_v;
		pc4_i = pc4_v;
		inst_i = inst_v;
		wb_sel_i = pipe_pkg::WB_PC4;
		reg_wen_i = 1'b1;
		rd_i = 5'd17;
		@(posedge clk_i);
		@(negedge clk_i);
		check_word("alu_wb_o", alu_wb_o, alu_v);
		check_word("pc4_wb_o", pc4_wb_o, pc4_v);
		check_word("inst_wb_o", inst_wb_o, inst_v);
		check_word("mem_wb_o", mem_wb_o, 32'd0);
		check_sel("wb_sel_wb_o", wb_sel_wb_o, pipe_pkg::WB_PC4);
		check_word("reg_wen_wb_o", 32'(reg_wen_wb_o), 32'd1);
		check_word("rd_wb_o", 32'(rd_wb_o), 32'd17);
		// register frozen while disabled
		enable_i = 1'b0;
		alu_i = next_random();
		pc4_i = next_random();
		inst_i = next_random();
		rd_i = 5'd3;
		@(posedge clk_i);
		@(negedge clk_i);
		check_word("alu_wb_o", alu_wb_o, alu_v);
		check_word("pc4_wb_o", pc4_wb_o, pc4_v);
		check_word("inst_wb_o", inst_wb_o, inst_v);
		check_word("rd_wb_o", 32'(rd_wb_o), 32'd17);
		// flush loads a bubble
		enable_i = 1'b1;
		flush_i = 1'b1;
		@(posedge clk_i);
		@(negedge clk_i);
		check_word("alu_wb_o", alu_wb_o, 32'd0);
		check_word("pc4_wb_o", pc4_wb_o, 32'd0);
		check_word("inst_wb_o", inst_wb_o, 32'd0);
		check_sel("wb_sel_wb_o", wb_sel_wb_o, pipe_pkg::WB_ALU);
		check_word("reg_wen_wb_o", 32'(reg_wen_wb_o), 32'd0);
		check_word("rd_wb_o", 32'(rd_wb_o), 32'd0);
		flush_i = 1'b0;
		reg_wen_i = 1'b0;
		// fetch stall blocks the memory request
		stall_by_icache_i = 1'b1;
		mem_op_i = pipe_pkg::MEM_LOAD;
		alu_i = 32'h0000_0140;
		repeat (3) begin
			#10;
			check_word("stall_o", 32'(stall_o), 32'd0);
			@(negedge clk_i);
		end
		check_counters();
		stall_by_icache_i = 1'b0;
		mem_op_i = pipe_pkg::MEM_NONE;
		end_test("pipeline_control");
	endtask

	task automatic test_random();
		logic              stalled;
		logic [31:0]       r, addr;
		pipe_pkg::mem_op_e op;
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			// three tags over lines 5 and 6, upper bits only
			addr = (({16'd0, r[31:16]} % 32'd3) << 8) | ((32'd5 + 32'(r[14])) << 4) |
				(32'(r[13:12]) << 2);
			op = r[15] ? pipe_pkg::MEM_STORE : pipe_pkg::MEM_LOAD;
			do_access(op, addr, next_random(), stalled);
		end
		check_counters();
		end_test("random_sequence");
	endtask

	initial begin
		rst_ni = 1'b0;
		alu_i = '0;
		rs2_i = '0;
		pc4_i = '0;
		inst_i = '0;
		mem_op_i = pipe_pkg::MEM_NONE;
		wb_sel_i = pipe_pkg::WB_ALU;
		reg_wen_i = 1'b0;
		rd_i = '0;
		enable_i = 1'b1;
		flush_i = 1'b0;
		stall_by_icache_i = 1'b0;
		lcg_state = 32'hbd8c_d0e3;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		exp_acc = '0;
		exp_hit = '0;
		exp_miss = '0;
		model_valid = '0;
		// memory starts with the address xor pattern
		for (int w = 0; w < MEM_WORDS; w++) begin
			model_mem[w] = w ^ 32'hA5A5_0000;
		end
		for (int k = 0; k < 4; k++) begin
			model_io[k] = '0;
		end
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		test_reset();
		test_cached_loads();
		test_eviction();
		test_io();
		test_pipeline();
		test_random();
		total_errors = errors + DUT.u_mem_stage.u_props.fail_count;
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
source/cache_pkg.sv
source/pipe_pkg.sv
source/mem_bus_if.sv
source/d_cache.sv
source/io_regs.sv
source/main_memory.sv
source/mem_stage.sv
source/mem_subsys_top.sv
bench/mem_subsys_properties.sv
bench/tb_mem_subsys.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsys
FILELIST  = build.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
